/* src/rx_pkg.sv */
package rx_pkg;

    //////////////////////////////
    // basic types
    //////////////////////////////

    typedef logic [7:0] byte_t;
    typedef logic [15:0] pkt_len_t;

    // bit 7 set for HT, low bits hold legacy rate code or MCS
    typedef logic [7:0] pkt_rate_t;

    typedef logic [7:0] crc8_t;
    typedef logic [31:0] crc32_t;

    //////////////////////////////
    // header fields
    //////////////////////////////

    // declared msb first, rate sits in the low bits
    typedef struct packed {
        logic [5:0]  tail;
        logic        parity;
        logic [11:0] length;
        logic        rsvd;
        logic [3:0]  rate;
    } legacy_sig_t;

    // sig2 in the upper 24 bits, sig1 in the lower 24 bits
    typedef struct packed {
        logic [5:0]  tail;
        crc8_t       crc;
        logic [1:0]  num_ext;
        logic        sgi;
        logic        fec;
        logic [1:0]  stbc;
        logic        aggr;
        logic        rsvd;
        logic        not_sounding;
        logic        smoothing;
        logic [15:0] length;
        logic        cbw;
        logic [6:0]  mcs;
    } ht_sig_t;

    typedef enum logic [3:0] {
        ST_OK,
        ST_PARITY_FAIL,
        ST_WRONG_RSVD,
        ST_WRONG_TAIL,
        ST_UNSUPPORTED_RATE,
        ST_WRONG_CRC,
        ST_UNSUPPORTED_MCS,
        ST_UNSUPPORTED_CBW,
        ST_HT_WRONG_RSVD,
        ST_UNSUPPORTED_STBC,
        ST_UNSUPPORTED_FEC,
        ST_UNSUPPORTED_SPATIAL,
        ST_HT_WRONG_TAIL,
        ST_UNSUPPORTED_AGGR,
        ST_WRONG_FCS
    } rx_status_t;

    //////////////////////////////
    // protocol constants
    //////////////////////////////

    // 6 Mb/s, may be followed by HT-SIG
    localparam logic [3:0] RATE_6M = 4'b1011;
    localparam logic [6:0] MAX_HT_MCS = 7'd7;
    localparam int unsigned HT_CRC_BITS = 34;

    // x^8 + x^2 + x + 1
    localparam crc8_t CRC8_POLY = 8'h07;
    // 0x04C11DB7 in reflected form
    localparam crc32_t CRC32_POLY = 32'hEDB88320;
    localparam crc32_t FCS_RESIDUE = 32'hDEBB20E3;
    localparam pkt_len_t FCS_BYTES = 16'd4;

endpackage

/* src/signal_parser.sv */
module signal_parser (
    input  logic                clock,
    input  logic                equalizer_reset,
    input  rx_pkg::byte_t       byte_i,
    input  logic                byte_stb_i,
    input  logic                capture_i,
    output rx_pkg::legacy_sig_t sig_o,
    output rx_pkg::rx_status_t  status_o
);
    import rx_pkg::*;

    legacy_sig_t sig_q;

    // bytes arrive lsb first, newest byte enters at the top
    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            sig_q <= '0;
        end else if (capture_i && byte_stb_i) begin
            sig_q <= legacy_sig_t'({byte_i, sig_q[23:8]});
        end
    end

    assign sig_o = sig_q;

    //////////////////////////////
    // field checks
    //////////////////////////////

    // first failing check wins
    always_comb begin
        if (^sig_q[17:0]) begin
            status_o = ST_PARITY_FAIL;
        end else if (sig_q.rsvd) begin
            status_o = ST_WRONG_RSVD;
        end else if (sig_q.tail != 6'd0) begin
            status_o = ST_WRONG_TAIL;
        end else if (!sig_q.rate[3]) begin
            // all valid rate codes have the top bit set
            status_o = ST_UNSUPPORTED_RATE;
        end else begin
            status_o = ST_OK;
        end
    end

endmodule

/* src/ht_sig_checker.sv */
module ht_sig_checker (
    input  logic               clock,
    input  logic               equalizer_reset,
    input  rx_pkg::byte_t      byte_i,
    input  logic               byte_stb_i,
    input  logic               capture_i,
    input  logic               start_i,
    output rx_pkg::ht_sig_t    sig_o,
    output logic               done_o,
    output rx_pkg::rx_status_t status_o
);
    import rx_pkg::*;

    ht_sig_t    sig_q;
    logic [5:0] bit_cnt;
    logic       busy;
    crc8_t      crc_q;
    crc8_t      crc_calc;
    logic       crc_fb;
    rx_status_t verdict;

    assign sig_o = sig_q;

    // serial crc8, one header bit per cycle starting from bit 0
    assign crc_fb = crc_q[7] ^ sig_q[bit_cnt];

    // transmitted crc is the inverted register, c7 first
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            crc_calc[i] = ~crc_q[7 - i];
        end
    end

    //////////////////////////////
    // verdict
    //////////////////////////////

    always_comb begin
        if (crc_calc != sig_q.crc) begin
            verdict = ST_WRONG_CRC;
        end else if (sig_q.mcs > MAX_HT_MCS) begin
            verdict = ST_UNSUPPORTED_MCS;
        end else if (sig_q.cbw) begin
            // 40 MHz not handled
            verdict = ST_UNSUPPORTED_CBW;
        end else if (!sig_q.rsvd) begin
            verdict = ST_HT_WRONG_RSVD;
        end else if (sig_q.stbc != 2'd0) begin
            verdict = ST_UNSUPPORTED_STBC;
        end else if (sig_q.fec) begin
            // ldpc
            verdict = ST_UNSUPPORTED_FEC;
        end else if (sig_q.num_ext != 2'd0) begin
            verdict = ST_UNSUPPORTED_SPATIAL;
        end else if (sig_q.tail != 6'd0) begin
            verdict = ST_HT_WRONG_TAIL;
        end else if (sig_q.aggr) begin
            verdict = ST_UNSUPPORTED_AGGR;
        end else begin
            verdict = ST_OK;
        end
    end

    //////////////////////////////
    // capture and crc sequencing
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            sig_q    <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
            crc_q    <= '1;
            done_o   <= 1'b0;
            status_o <= ST_OK;
        end else begin
            done_o <= 1'b0;
            if (capture_i && byte_stb_i) begin
                sig_q <= ht_sig_t'({byte_i, sig_q[47:8]});
            end
            if (start_i) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                crc_q   <= '1;
            end else if (busy) begin
                if (bit_cnt != 6'(HT_CRC_BITS)) begin
                    crc_q   <= {crc_q[6:0], 1'b0} ^ (crc_fb ? CRC8_POLY : 8'h00);
                    bit_cnt <= bit_cnt + 6'd1;
                end else begin
                    // all covered bits shifted in
                    busy     <= 1'b0;
                    done_o   <= 1'b1;
                    status_o <= verdict;
                end
            end
        end
    end

endmodule

/* src/fcs_checker.sv */
module fcs_checker (
    input  logic          clock,
    input  logic          equalizer_reset,
    input  logic          clear_i,
    input  logic          stb_i,
    input  rx_pkg::byte_t byte_i,
    output logic          fcs_ok_o
);
    import rx_pkg::*;

    crc32_t crc_q;
    crc32_t crc_next;

    // reflected crc32, byte bits taken lsb first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ byte_i[i]) begin
                crc_next = (crc_next >> 1) ^ CRC32_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (equalizer_reset || clear_i) begin
            crc_q <= '1;
        end else if (stb_i) begin
            crc_q <= crc_next;
        end
    end

    // fcs included in the stream, so a good frame leaves the residue
    assign fcs_ok_o = (crc_q == FCS_RESIDUE);

endmodule

/* src/rx_ctrl.sv */
module rx_ctrl (
    input  logic                clock,
    input  logic                equalizer_reset,
    input  logic                start_i,
    input  rx_pkg::byte_t       byte_i,
    input  logic                byte_stb_i,
    input  logic                ht_decide_stb_i,
    input  logic                ht_decide_i,
    input  rx_pkg::legacy_sig_t legacy_sig_i,
    input  rx_pkg::rx_status_t  legacy_status_i,
    input  rx_pkg::ht_sig_t     ht_sig_i,
    input  logic                ht_done_i,
    input  rx_pkg::rx_status_t  ht_status_i,
    input  logic                fcs_ok_i,
    output logic                sig_capture_o,
    output logic                ht_capture_o,
    output logic                ht_start_o,
    output logic                fcs_clear_o,
    output logic                fcs_stb_o,
    output rx_pkg::byte_t       data_o,
    output logic                data_stb_o,
    output logic                demod_ongoing_o,
    output logic                pkt_header_valid_o,
    output logic                pkt_header_valid_stb_o,
    output logic                pkt_ht_o,
    output rx_pkg::pkt_rate_t   pkt_rate_o,
    output rx_pkg::pkt_len_t    pkt_len_o,
    output logic                fcs_out_stb_o,
    output logic                fcs_ok_o,
    output rx_pkg::rx_status_t  status_o
);
    import rx_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SIGNAL,
        CHECK_SIGNAL,
        WAIT_HT,
        HT_SIGNAL,
        CHECK_HT,
        DATA,
        DONE
    } state_t;

    state_t   state;
    pkt_len_t byte_cnt;
    logic     data_take;
    logic     byte_take;
    logic     fcs_good;

    assign sig_capture_o   = (state == SIGNAL);
    assign ht_capture_o    = (state == HT_SIGNAL);
    assign demod_ongoing_o = (state != IDLE);
    // checker held at its initial value outside the data phase
    assign fcs_clear_o     = (state != DATA);

    // stop taking bytes once the packet length is reached
    assign data_take = (state == DATA) && byte_stb_i && (byte_cnt != pkt_len_o);
    assign byte_take = data_take || (byte_stb_i && (sig_capture_o || ht_capture_o));
    assign fcs_stb_o = data_take;
    assign fcs_good  = fcs_ok_i && (pkt_len_o >= FCS_BYTES);

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            state                  <= IDLE;
            byte_cnt               <= '0;
            ht_start_o             <= 1'b0;
            data_stb_o             <= 1'b0;
            pkt_header_valid_o     <= 1'b0;
            pkt_header_valid_stb_o <= 1'b0;
            pkt_ht_o               <= 1'b0;
            pkt_rate_o             <= '0;
            pkt_len_o              <= '0;
            fcs_out_stb_o          <= 1'b0;
            fcs_ok_o               <= 1'b0;
            status_o               <= ST_OK;
        end else begin
            // pulses by default
            ht_start_o             <= 1'b0;
            pkt_header_valid_o     <= 1'b0;
            pkt_header_valid_stb_o <= 1'b0;
            fcs_out_stb_o          <= 1'b0;
            data_stb_o             <= data_take;
            if (data_take) begin
                data_o <= byte_i;
            end
            if (byte_take) begin
                byte_cnt <= byte_cnt + 16'd1;
            end

            case (state)
                IDLE: begin
                    if (start_i) begin
                        byte_cnt <= '0;
                        pkt_ht_o <= 1'b0;
                        state    <= SIGNAL;
                    end
                end

                SIGNAL: begin
                    if (byte_stb_i && byte_cnt == 16'd2) begin
                        state <= CHECK_SIGNAL;
                    end
                end

                //////////////////////////////
                // legacy header decision
                //////////////////////////////
                CHECK_SIGNAL: begin
                    byte_cnt   <= '0;
                    pkt_rate_o <= {4'b0000, legacy_sig_i.rate};
                    pkt_len_o  <= pkt_len_t'(legacy_sig_i.length);
                    status_o   <= legacy_status_i;
                    if (legacy_status_i != ST_OK) begin
                        pkt_header_valid_stb_o <= 1'b1;
                        state                  <= IDLE;
                    end else if (legacy_sig_i.rate == RATE_6M) begin
                        // could still be HT mixed mode
                        state <= WAIT_HT;
                    end else begin
                        pkt_header_valid_o     <= 1'b1;
                        pkt_header_valid_stb_o <= 1'b1;
                        state                  <= DATA;
                    end
                end

                WAIT_HT: begin
                    if (ht_decide_stb_i) begin
                        if (ht_decide_i) begin
                            state <= HT_SIGNAL;
                        end else begin
                            pkt_header_valid_o     <= 1'b1;
                            pkt_header_valid_stb_o <= 1'b1;
                            state                  <= DATA;
                        end
                    end
                end

                HT_SIGNAL: begin
                    if (byte_stb_i && byte_cnt == 16'd5) begin
                        ht_start_o <= 1'b1;
                        state      <= CHECK_HT;
                    end
                end

                // wait for the serial crc and field checks
                CHECK_HT: begin
                    if (ht_done_i) begin
                        byte_cnt               <= '0;
                        pkt_ht_o               <= 1'b1;
                        pkt_rate_o             <= {1'b1, ht_sig_i.mcs};
                        pkt_len_o              <= ht_sig_i.length;
                        status_o               <= ht_status_i;
                        pkt_header_valid_stb_o <= 1'b1;
                        if (ht_status_i == ST_OK) begin
                            pkt_header_valid_o <= 1'b1;
                            state              <= DATA;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end

                //////////////////////////////
                // payload and fcs
                //////////////////////////////
                DATA: begin
                    if (byte_cnt == pkt_len_o) begin
                        fcs_out_stb_o <= 1'b1;
                        fcs_ok_o      <= fcs_good;
                        status_o      <= fcs_good ? ST_OK : ST_WRONG_FCS;
                        state         <= DONE;
                    end
                end

                DONE: begin
                    fcs_ok_o <= 1'b0;
                    state    <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* src/rx_top.sv */
module rx_top (
    input  logic              clock,
    input  logic              equalizer_reset,
    input  logic              start_i,
    input  rx_pkg::byte_t     byte_i,
    input  logic              byte_stb_i,
    input  logic              ht_decide_stb_i,
    input  logic              ht_decide_i,
    output rx_pkg::byte_t     data_o,
    output logic              data_stb_o,
    output logic              demod_ongoing_o,
    output logic              pkt_header_valid_o,
    output logic              pkt_header_valid_stb_o,
    output logic              pkt_ht_o,
    output rx_pkg::pkt_rate_t pkt_rate_o,
    output rx_pkg::pkt_len_t  pkt_len_o,
    output logic              fcs_stb_o,
    output logic              fcs_ok_o,
    output rx_pkg::rx_status_t status_o
);
    import rx_pkg::*;

    logic        sig_capture;
    logic        ht_capture;
    logic        ht_check_start;
    logic        ht_done;
    logic        fcs_clear;
    logic        fcs_stb;
    logic        fcs_ok;
    legacy_sig_t legacy_sig;
    rx_status_t  legacy_status;
    ht_sig_t     ht_sig;
    rx_status_t  ht_status;

    signal_parser u_signal_parser (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .byte_i          (byte_i),
        .byte_stb_i      (byte_stb_i),
        .capture_i       (sig_capture),
        .sig_o           (legacy_sig),
        .status_o        (legacy_status)
    );

    ht_sig_checker u_ht_sig_checker (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .byte_i          (byte_i),
        .byte_stb_i      (byte_stb_i),
        .capture_i       (ht_capture),
        .start_i         (ht_check_start),
        .sig_o           (ht_sig),
        .done_o          (ht_done),
        .status_o        (ht_status)
    );

    // fed straight from the input byte, gated by the controller
    fcs_checker u_fcs_checker (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .clear_i         (fcs_clear),
        .stb_i           (fcs_stb),
        .byte_i          (byte_i),
        .fcs_ok_o        (fcs_ok)
    );

    rx_ctrl u_rx_ctrl (
        .clock                  (clock),
        .equalizer_reset        (equalizer_reset),
        .start_i                (start_i),
        .byte_i                 (byte_i),
        .byte_stb_i             (byte_stb_i),
        .ht_decide_stb_i        (ht_decide_stb_i),
        .ht_decide_i            (ht_decide_i),
        .legacy_sig_i           (legacy_sig),
        .legacy_status_i        (legacy_status),
        .ht_sig_i               (ht_sig),
        .ht_done_i              (ht_done),
        .ht_status_i            (ht_status),
        .fcs_ok_i               (fcs_ok),
        .sig_capture_o          (sig_capture),
        .ht_capture_o           (ht_capture),
        .ht_start_o             (ht_check_start),
        .fcs_clear_o            (fcs_clear),
        .fcs_stb_o              (fcs_stb),
        .data_o                 (data_o),
        .data_stb_o             (data_stb_o),
        .demod_ongoing_o        (demod_ongoing_o),
        .pkt_header_valid_o     (pkt_header_valid_o),
        .pkt_header_valid_stb_o (pkt_header_valid_stb_o),
        .pkt_ht_o               (pkt_ht_o),
        .pkt_rate_o             (pkt_rate_o),
        .pkt_len_o              (pkt_len_o),
        .fcs_out_stb_o          (fcs_stb_o),
        .fcs_ok_o               (fcs_ok_o),
        .status_o               (status_o)
    );

endmodule

/* testbench/tb_rx_model.svh */
`ifndef TB_RX_MODEL_SVH
`define TB_RX_MODEL_SVH

int unsigned lcg_state = 17;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

// legacy SIGNAL word with even parity over bits 0 to 17
function automatic logic [23:0] legacy_word(input logic [3:0] rate, input logic rsvd,
                                            input logic [11:0] len, input logic [5:0] tail);
    logic [23:0] w;
    w = {tail, 1'b0, len, rsvd, rate};
    w[17] = ^w[16:0];
    return w;
endfunction

// crc field of HT-SIG, 34 bits lsb first into x^8+x^2+x+1
function automatic logic [7:0] ht_crc8(input logic [47:0] w);
    logic [7:0] c;
    logic [7:0] field;
    logic       fb;
    c = 8'hff;
    for (int i = 0; i < 34; i++) begin
        fb = c[7] ^ w[i];
        c = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
    end
    for (int i = 0; i < 8; i++) begin
        field[i] = ~c[7 - i];
    end
    return field;
endfunction

// rsvd and not_sounding set, the other flags clear unless given
function automatic logic [47:0] ht_word(input logic [6:0] mcs, input logic cbw,
                                        input logic [15:0] len, input logic aggr,
                                        input logic [1:0] stbc);
    logic [47:0] w;
    w = {6'd0, 8'd0, 2'd0, 1'b0, 1'b0, stbc, aggr, 1'b1, 1'b1, 1'b0, len, cbw, mcs};
    w[41:34] = ht_crc8(w);
    return w;
endfunction

// reflected form of 0x04C11DB7
function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input byte_t b);
    for (int i = 0; i < 8; i++) begin
        if (crc[0] ^ b[i])
            crc = (crc >> 1) ^ 32'hEDB88320;
        else
            crc = crc >> 1;
    end
    return crc;
endfunction

function automatic rx_status_t legacy_status_ref(input logic [23:0] w);
    if (^w[17:0]) return ST_PARITY_FAIL;
    if (w[4]) return ST_WRONG_RSVD;
    if (w[23:18] != 6'd0) return ST_WRONG_TAIL;
    if (!w[3]) return ST_UNSUPPORTED_RATE;
    return ST_OK;
endfunction

function automatic rx_status_t ht_status_ref(input logic [47:0] w);
    if (ht_crc8(w) != w[41:34]) return ST_WRONG_CRC;
    if (w[6:0] > MAX_HT_MCS) return ST_UNSUPPORTED_MCS;
    if (w[7]) return ST_UNSUPPORTED_CBW;
    if (!w[26]) return ST_HT_WRONG_RSVD;
    if (w[29:28] != 2'd0) return ST_UNSUPPORTED_STBC;
    if (w[30]) return ST_UNSUPPORTED_FEC;
    if (w[33:32] != 2'd0) return ST_UNSUPPORTED_SPATIAL;
    if (w[47:42] != 6'd0) return ST_HT_WRONG_TAIL;
    if (w[27]) return ST_UNSUPPORTED_AGGR;
    return ST_OK;
endfunction

`endif

/* testbench/tb_rx_top.sv */
module tb_rx_top;
    timeunit 1ns;
    timeprecision 1ps;

    import rx_pkg::*;

    `include "tb_rx_model.svh"

    logic       clock;
    logic       equalizer_reset;
    logic       start_i;
    byte_t      byte_i;
    logic       byte_stb_i;
    logic       ht_decide_stb_i;
    logic       ht_decide_i;
    byte_t      data_o;
    logic       data_stb_o;
    logic       demod_ongoing_o;
    logic       pkt_header_valid_o;
    logic       pkt_header_valid_stb_o;
    logic       pkt_ht_o;
    pkt_rate_t  pkt_rate_o;
    pkt_len_t   pkt_len_o;
    logic       fcs_stb_o;
    logic       fcs_ok_o;
    rx_status_t status_o;

    // expectations for the packet in flight
    string      test_name;
    logic       exp_valid;
    logic       exp_ht;
    pkt_rate_t  exp_rate;
    pkt_len_t   exp_len;
    rx_status_t exp_hdr_status;
    logic       exp_fcs_ok;
    rx_status_t exp_status;
    byte_t      exp_bytes[$];
    int         rx_count;
    int         hdr_count;
    int         test_errors;
    int         pass_count;
    int         fail_count;
    logic       aborted;

    rx_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic report_value(input string field, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("MISMATCH test %s %s expected %0h actual %0h", test_name, field, exp, act);
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR test %s: %s", test_name, what);
        test_errors++;
    endtask

    //////////////////////////////
    // comparing process
    //////////////////////////////

    always @(negedge clock) begin
        if (!equalizer_reset && pkt_header_valid_stb_o) begin
            hdr_count++;
            if (pkt_header_valid_o !== exp_valid)
                report_value("header valid", exp_valid, pkt_header_valid_o);
            if (pkt_ht_o !== exp_ht)
                report_value("ht flag", exp_ht, pkt_ht_o);
            if (status_o !== exp_hdr_status)
                report_value("header status", exp_hdr_status, status_o);
            // busy only when the header leads into the data phase
            if (demod_ongoing_o !== exp_valid)
                report_value("demod ongoing", exp_valid, demod_ongoing_o);
            if (exp_valid && pkt_rate_o !== exp_rate)
                report_value("rate", exp_rate, pkt_rate_o);
            if (exp_valid && pkt_len_o !== exp_len)
                report_value("length", exp_len, pkt_len_o);
        end
        if (!equalizer_reset && data_stb_o) begin
            if (!exp_valid)
                report_problem("data strobe after a rejected header");
            else if (rx_count >= exp_bytes.size())
                report_problem("more data bytes than the packet length");
            else if (data_o !== exp_bytes[rx_count])
                report_value("data byte", exp_bytes[rx_count], data_o);
            rx_count++;
        end
        if (!equalizer_reset && fcs_stb_o) begin
            if (!exp_valid)
                report_problem("FCS strobe after a rejected header");
            if (rx_count != exp_bytes.size())
                report_value("byte count", exp_bytes.size(), rx_count);
            if (fcs_ok_o !== exp_fcs_ok)
                report_value("fcs ok", exp_fcs_ok, fcs_ok_o);
            if (status_o !== exp_status)
                report_value("final status", exp_status, status_o);
        end
    end

    task automatic close_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s ok", test_name);
        end else begin
            fail_count++;
            $display("test %s FAILED with %0d errors", test_name, test_errors);
        end
    endtask

    // remaining packets are skipped after a timeout
    task automatic abort_test(input string what);
        report_problem(what);
        aborted = 1'b1;
        close_test();
    endtask

    task automatic finish_run();
        $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
                 fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // entered and left on a falling edge
    task automatic send_byte(input byte_t b);
        int gap;
        gap = lcg_next() % 3;
        byte_stb_i = 1'b0;
        repeat (gap) @(negedge clock);
        byte_i = b;
        byte_stb_i = 1'b1;
        @(negedge clock);
        byte_stb_i = 1'b0;
    endtask

    //////////////////////////////
    // packet driver
    //////////////////////////////

    task automatic run_packet(input string name, input logic [23:0] sig_w, input logic ht_flag,
                              input logic [47:0] ht_w, input int flip_idx);
        rx_status_t  lstat;
        logic        ht_path;
        logic [31:0] crc;
        byte_t       tx[$];
        int          n;
        int          waited;
        if (aborted)
            return;
        test_name = name;
        lstat = legacy_status_ref(sig_w);
        ht_path = (lstat == ST_OK) && (sig_w[3:0] == RATE_6M) && ht_flag;
        exp_ht = ht_path;
        if (ht_path) begin
            exp_hdr_status = ht_status_ref(ht_w);
            exp_rate = {1'b1, ht_w[6:0]};
            exp_len = ht_w[23:8];
        end else begin
            exp_hdr_status = lstat;
            exp_rate = {4'b0000, sig_w[3:0]};
            exp_len = pkt_len_t'(sig_w[16:5]);
        end
        exp_valid = (exp_hdr_status == ST_OK);
        if (exp_valid) begin
            // payload then FCS, lsb first
            n = int'(exp_len) - 4;
            crc = '1;
            for (int i = 0; i < n; i++) begin
                tx.push_back(byte_t'(lcg_next()));
                crc = crc32_byte(crc, tx[i]);
            end
            for (int i = 0; i < 4; i++)
                tx.push_back(byte_t'(~crc >> (8 * i)));
            if (flip_idx >= 0)
                tx[flip_idx] = tx[flip_idx] ^ 8'h10;
            crc = '1;
            for (int i = 0; i < n; i++)
                crc = crc32_byte(crc, tx[i]);
            exp_fcs_ok = (~crc == {tx[n + 3], tx[n + 2], tx[n + 1], tx[n]});
            exp_status = exp_fcs_ok ? ST_OK : ST_WRONG_FCS;
        end
        exp_bytes = tx;
        rx_count = 0;
        hdr_count = 0;
        test_errors = 0;

        start_i = 1'b1;
        @(negedge clock);
        start_i = 1'b0;
        for (int i = 0; i < 3; i++)
            send_byte(sig_w[8 * i +: 8]);
        if (lstat == ST_OK && sig_w[3:0] == RATE_6M) begin
            // controller needs two cycles to reach the decision wait
            repeat (2) @(negedge clock);
            ht_decide_i = ht_flag;
            ht_decide_stb_i = 1'b1;
            @(negedge clock);
            ht_decide_stb_i = 1'b0;
            if (ht_flag) begin
                for (int i = 0; i < 6; i++)
                    send_byte(ht_w[8 * i +: 8]);
            end
        end

        waited = 0;
        while (!pkt_header_valid_stb_o && waited < 200) begin
            @(negedge clock);
            waited++;
        end
        if (!pkt_header_valid_stb_o) begin
            abort_test("timeout waiting for the header strobe");
            return;
        end
        if (exp_valid) begin
            foreach (tx[i])
                send_byte(tx[i]);
            waited = 0;
            while (!fcs_stb_o && waited < 20) begin
                @(negedge clock);
                waited++;
            end
            if (!fcs_stb_o) begin
                abort_test("timeout waiting for the FCS strobe");
                return;
            end
        end
        repeat (4) @(negedge clock);
        if (demod_ongoing_o !== 1'b0)
            report_problem("controller did not return to idle");
        if (hdr_count != 1)
            report_value("header strobe count", 1, hdr_count);
        close_test();
    endtask

    initial begin
        logic [23:0] sig_24m;
        logic [23:0] sig_6m;
        equalizer_reset = 1'b1;
        start_i = 1'b0;
        byte_i = '0;
        byte_stb_i = 1'b0;
        ht_decide_stb_i = 1'b0;
        ht_decide_i = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_errors = 0;
        aborted = 1'b0;
        test_name = "reset_state";
        exp_valid = 1'b0;
        sig_24m = legacy_word(4'b1001, 1'b0, 12'd16, 6'd0);
        sig_6m = legacy_word(RATE_6M, 1'b0, 12'd40, 6'd0);
        repeat (2) @(posedge clock);
        @(negedge clock);
        equalizer_reset = 1'b0;
        @(negedge clock);
        if (data_stb_o || pkt_header_valid_stb_o || fcs_stb_o || pkt_header_valid_o)
            report_problem("strobes or header valid high after reset");
        if (pkt_ht_o || demod_ongoing_o)
            report_problem("ht flag or demod flag high after reset");
        if (status_o !== ST_OK)
            report_value("status", ST_OK, status_o);
        close_test();

        run_packet("legacy_24m", sig_24m, 1'b0, '0, -1);
        run_packet("legacy_bad_fcs", sig_24m, 1'b0, '0, 5);
        run_packet("sig_parity", sig_24m ^ 24'h020000, 1'b0, '0, -1);
        run_packet("sig_rsvd", legacy_word(4'b1001, 1'b1, 12'd16, 6'd0), 1'b0, '0, -1);
        run_packet("sig_tail", legacy_word(4'b1001, 1'b0, 12'd16, 6'd5), 1'b0, '0, -1);
        run_packet("sig_rate", legacy_word(4'b0011, 1'b0, 12'd16, 6'd0), 1'b0, '0, -1);
        run_packet("ht_mcs3", sig_6m, 1'b1, ht_word(7'd3, 1'b0, 16'd24, 1'b0, 2'd0), -1);
        run_packet("ht_crc", sig_6m, 1'b1,
                   ht_word(7'd3, 1'b0, 16'd24, 1'b0, 2'd0) ^ (48'h1 << 36), -1);
        run_packet("ht_mcs9", sig_6m, 1'b1, ht_word(7'd9, 1'b0, 16'd24, 1'b0, 2'd0), -1);
        run_packet("ht_cbw", sig_6m, 1'b1, ht_word(7'd3, 1'b1, 16'd24, 1'b0, 2'd0), -1);
        run_packet("ht_stbc", sig_6m, 1'b1, ht_word(7'd3, 1'b0, 16'd24, 1'b0, 2'd1), -1);
        run_packet("ht_aggr", sig_6m, 1'b1, ht_word(7'd3, 1'b0, 16'd24, 1'b1, 2'd0), -1);
        run_packet("legacy_6m", legacy_word(RATE_6M, 1'b0, 12'd14, 6'd0), 1'b0, '0, -1);
        finish_run();
    end

endmodule

/* flist.f */
+incdir+testbench
src/rx_pkg.sv
src/signal_parser.sv
src/ht_sig_checker.sv
src/fcs_checker.sv
src/rx_ctrl.sv
src/rx_top.sv
testbench/tb_rx_top.sv
